//--- rtr_cfg_pkg.sv
// network geometry, port numbering and buffer sizing shared by every router block
package rtr_cfg_pkg;

   // ------------------------------
   // ports
   // ------------------------------

   // four mesh neighbours plus the local node
   localparam int num_ports = 5;

   typedef logic [2:0]           port_idx_t;
   typedef logic [num_ports-1:0] port_vec_t;

   // fixed port order, x dimension first
   localparam port_idx_t port_x_minus = 3'd0;
   localparam port_idx_t port_x_plus  = 3'd1;
   localparam port_idx_t port_y_minus = 3'd2;
   localparam port_idx_t port_y_plus  = 3'd3;
   localparam port_idx_t port_node    = 3'd4;

   // ------------------------------
   // addressing and buffering
   // ------------------------------

   // 4x4 mesh, x in the low bits and y in the high bits
   localparam int dim_addr_width = 2;
   typedef logic [2*dim_addr_width-1:0] router_addr_t;

   // flits per input buffer, equal to the credits an output starts with
   localparam int buffer_depth = 4;
   typedef logic [2:0] credit_cnt_t;

   localparam int flit_data_width = 16;

endpackage

//--- rtr_flit_pkg.sv
// flit, request and routing types passed between the input side, allocator and output side
package rtr_flit_pkg;

   // ------------------------------
   // link flit
   // ------------------------------

   // head flit carries the destination router in data[3:0]
   typedef struct packed
   {
      logic                                     valid;
      logic                                     head;
      logic                                     tail;
      logic [rtr_cfg_pkg::flit_data_width-1:0]  data;
   } flit_t;

   // ------------------------------
   // input to allocator
   // ------------------------------

   // route is one-hot over the output ports
   typedef struct packed
   {
      logic                   valid;
      logic                   head;
      logic                   tail;
      rtr_cfg_pkg::port_vec_t route;
   } ip_req_t;

   // buffer head flit of every input, indexed by input port
   typedef flit_t [rtr_cfg_pkg::num_ports-1:0] flit_arr_t;

endpackage

//--- rtr_flit_fifo.sv
// per-input flit buffer, written by the upstream link and popped when the allocator sends
module rtr_flit_fifo
(
   input  logic                clk,
   input  logic                arst_n,
   input  rtr_flit_pkg::flit_t wr_flit,
   input  logic                rd_pop,
   output rtr_flit_pkg::flit_t head_flit,
   output logic                overflow
);
   import rtr_cfg_pkg::*;
   import rtr_flit_pkg::*;

   // storage, no reset needed
   flit_t                           mem [buffer_depth];
   logic [$clog2(buffer_depth)-1:0] wr_ptr_q;
   logic [$clog2(buffer_depth)-1:0] rd_ptr_q;
   // occupancy, one bit wider than the pointers to tell full from empty
   logic [$clog2(buffer_depth):0]   count_q;
   logic                            full;
   logic                            empty;
   logic                            push;
   logic                            pop;

   assign full  = (count_q == buffer_depth);
   assign empty = (count_q == '0);
   // a write into a full buffer is lost
   assign push     = wr_flit.valid && !full;
   assign pop      = rd_pop && !empty;
   assign overflow = wr_flit.valid && full;

   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr_q] <= wr_flit;
   end

   // pointers wrap naturally, depth is a power of two
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         if (pop)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         if (push && !pop)
            count_q <= count_q + 1'b1;
         else if (pop && !push)
            count_q <= count_q - 1'b1;
      end
   end

   // head entry visible one edge after its write
   always_comb
   begin
      head_flit       = mem[rd_ptr_q];
      head_flit.valid = !empty;
   end

endmodule

//--- rtr_ip_ctrl.sv
// input controller, buffers link flits, routes heads in x-then-y order and returns credits upstream
module rtr_ip_ctrl
(
   input  logic                      clk,
   input  logic                      arst_n,
   input  rtr_cfg_pkg::router_addr_t router_address,
   input  rtr_flit_pkg::flit_t       channel_in,
   input  logic                      flit_sent,
   output rtr_flit_pkg::ip_req_t     req,
   output rtr_flit_pkg::flit_t       head_flit,
   output logic                      flow_ctrl_out,
   output logic                      error
);
   import rtr_cfg_pkg::*;
   import rtr_flit_pkg::*;

   router_addr_t dest;
   port_idx_t    head_port;
   port_vec_t    head_route;
   // route of the packet in flight, used by its body and tail flits
   port_vec_t    route_q;
   logic         flow_ctrl_q;

   // ------------------------------
   // flit buffer
   // ------------------------------

   rtr_flit_fifo fifo
   (
      .clk       (clk),
      .arst_n    (arst_n),
      .wr_flit   (channel_in),
      .rd_pop    (flit_sent),
      .head_flit (head_flit),
      .overflow  (error)
   );

   // ------------------------------
   // dimension-order routing
   // ------------------------------

   assign dest = head_flit.data[$bits(router_addr_t)-1:0];

   // resolve x fully before moving in y
   always_comb
   begin
      if (dest[dim_addr_width-1:0] > router_address[dim_addr_width-1:0])
         head_port = port_x_plus;
      else if (dest[dim_addr_width-1:0] < router_address[dim_addr_width-1:0])
         head_port = port_x_minus;
      else if (dest[2*dim_addr_width-1:dim_addr_width] >
               router_address[2*dim_addr_width-1:dim_addr_width])
         head_port = port_y_plus;
      else if (dest[2*dim_addr_width-1:dim_addr_width] <
               router_address[2*dim_addr_width-1:dim_addr_width])
         head_port = port_y_minus;
      else
         head_port = port_node;
   end

   assign head_route = port_vec_t'(1) << head_port;

   // capture route once the head has left
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         route_q <= '0;
      else if (flit_sent && head_flit.head)
         route_q <= head_route;
   end

   // request for the current buffer head
   assign req.valid = head_flit.valid;
   assign req.head  = head_flit.head;
   assign req.tail  = head_flit.tail;
   assign req.route = head_flit.head ? head_route : route_q;

   // ------------------------------
   // upstream credit return
   // ------------------------------

   // one credit per popped flit, one cycle after the pop
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         flow_ctrl_q <= 1'b0;
      else
         flow_ctrl_q <= flit_sent;
   end

   assign flow_ctrl_out = flow_ctrl_q;

endmodule

//--- rtr_sw_alloc.sv
// switch allocator, one round-robin arbiter per output that stays locked to a packet until its tail
module rtr_sw_alloc
(
   input  logic                                                 clk,
   input  logic                                                 arst_n,
   input  rtr_flit_pkg::ip_req_t [rtr_cfg_pkg::num_ports-1:0]   req,
   input  rtr_cfg_pkg::port_vec_t                               credit_avail,
   output rtr_cfg_pkg::port_vec_t                               flit_sent,
   output rtr_cfg_pkg::port_vec_t [rtr_cfg_pkg::num_ports-1:0]  grant
);
   import rtr_cfg_pkg::*;
   import rtr_flit_pkg::*;

   for (genvar o = 0; o < num_ports; o++)
   begin : g_op

      // ------------------------------
      // per-output state
      // ------------------------------

      // output held by a packet between head and tail
      logic      lock_vld_q;
      port_idx_t lock_ip_q;
      // last input served, search starts just after it
      port_idx_t rr_ptr_q;
      port_idx_t sel_ip;
      port_vec_t grant_o;

      always_comb
      begin : p_arb
         logic found;
         int   idx;
         grant_o = '0;
         sel_ip  = lock_ip_q;
         found   = 1'b0;
         idx     = 0;
         if (lock_vld_q)
         begin
            // locked, only the owner may send, one flit per credit
            if (credit_avail[o] && req[lock_ip_q].valid && req[lock_ip_q].route[o])
               grant_o[lock_ip_q] = 1'b1;
         end
         else if (credit_avail[o])
         begin
            // free, take the first head flit after the pointer
            for (int k = 1; k <= num_ports; k++)
            begin
               idx = (int'(rr_ptr_q) + k) % num_ports;
               if (!found && req[idx].valid && req[idx].head && req[idx].route[o])
               begin
                  found  = 1'b1;
                  sel_ip = port_idx_t'(idx);
               end
            end
            if (found)
               grant_o[sel_ip] = 1'b1;
         end
      end

      assign grant[o] = grant_o;

      // lock on a head, release on the edge the tail leaves
      always_ff @(posedge clk or negedge arst_n)
      begin
         if (!arst_n)
         begin
            lock_vld_q <= 1'b0;
            lock_ip_q  <= '0;
            rr_ptr_q   <= port_idx_t'(num_ports - 1);
         end
         else if (|grant_o)
         begin
            rr_ptr_q   <= sel_ip;
            lock_ip_q  <= sel_ip;
            lock_vld_q <= !req[sel_ip].tail;
         end
      end

   end

   // ------------------------------
   // pop strobes
   // ------------------------------

   // each input routes to one output, so at most one grant per input
   always_comb
   begin
      flit_sent = '0;
      for (int o = 0; o < num_ports; o++)
         flit_sent = flit_sent | grant[o];
   end

endmodule

//--- rtr_op_ctrl.sv
// output controller, crossbar mux onto a registered link plus the downstream credit counter
module rtr_op_ctrl
(
   input  logic                   clk,
   input  logic                   arst_n,
   input  rtr_cfg_pkg::port_vec_t grant,
   input  rtr_flit_pkg::flit_arr_t head_flits,
   input  logic                   flow_ctrl_in,
   output rtr_flit_pkg::flit_t    channel_out,
   output logic                   credit_avail,
   output logic                   error
);
   import rtr_cfg_pkg::*;
   import rtr_flit_pkg::*;

   flit_t       sel_flit;
   flit_t       out_flit_q;
   logic        out_valid_q;
   logic        consume;
   credit_cnt_t credit_q;

   // ------------------------------
   // crossbar column
   // ------------------------------

   // and-or mux, grant is one-hot or zero
   always_comb
   begin
      sel_flit = '0;
      for (int i = 0; i < num_ports; i++)
      begin
         if (grant[i])
            sel_flit = sel_flit | head_flits[i];
      end
   end

   assign consume = |grant;

   // payload only loads on a grant
   always_ff @(posedge clk)
   begin
      if (consume)
         out_flit_q <= sel_flit;
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         out_valid_q <= 1'b0;
      else
         out_valid_q <= consume;
   end

   always_comb
   begin
      channel_out       = out_flit_q;
      channel_out.valid = out_valid_q;
   end

   // ------------------------------
   // downstream credits
   // ------------------------------

   // a return while full and idle would exceed the buffer size
   assign error = flow_ctrl_in && !consume && (credit_q == credit_cnt_t'(buffer_depth));

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         credit_q <= credit_cnt_t'(buffer_depth);
      else if (consume && !flow_ctrl_in)
         credit_q <= credit_q - 1'b1;
      else if (flow_ctrl_in && !consume && !error)
         credit_q <= credit_q + 1'b1;
   end

   assign credit_avail = (credit_q != '0);

endmodule

//--- rtr_top.sv
// single-VC wormhole router for one mesh node, input controllers, allocator and output controllers
module rtr_top
(
   input  logic                    clk,
   input  logic                    arst_n,
   input  rtr_cfg_pkg::router_addr_t router_address,
   input  rtr_flit_pkg::flit_arr_t channel_in,
   output rtr_cfg_pkg::port_vec_t  flow_ctrl_out,
   output rtr_flit_pkg::flit_arr_t channel_out,
   input  rtr_cfg_pkg::port_vec_t  flow_ctrl_in,
   output logic                    error
);
   import rtr_cfg_pkg::*;
   import rtr_flit_pkg::*;

   ip_req_t [num_ports-1:0]   ip_req;
   flit_arr_t                 ip_head_flit;
   port_vec_t                 ip_error;
   port_vec_t                 flit_sent;
   port_vec_t [num_ports-1:0] op_grant;
   port_vec_t                 credit_avail;
   port_vec_t                 op_error;
   logic                      error_q;

   // ------------------------------
   // input side
   // ------------------------------

   for (genvar i = 0; i < num_ports; i++)
   begin : g_ip
      rtr_ip_ctrl ipc
      (
         .clk            (clk),
         .arst_n         (arst_n),
         .router_address (router_address),
         .channel_in     (channel_in[i]),
         .flit_sent      (flit_sent[i]),
         .req            (ip_req[i]),
         .head_flit      (ip_head_flit[i]),
         .flow_ctrl_out  (flow_ctrl_out[i]),
         .error          (ip_error[i])
      );
   end

   // switch allocation
   rtr_sw_alloc alo
   (
      .clk          (clk),
      .arst_n       (arst_n),
      .req          (ip_req),
      .credit_avail (credit_avail),
      .flit_sent    (flit_sent),
      .grant        (op_grant)
   );

   // ------------------------------
   // output side
   // ------------------------------

   for (genvar o = 0; o < num_ports; o++)
   begin : g_op
      rtr_op_ctrl opc
      (
         .clk          (clk),
         .arst_n       (arst_n),
         .grant        (op_grant[o]),
         .head_flits   (ip_head_flit),
         .flow_ctrl_in (flow_ctrl_in[o]),
         .channel_out  (channel_out[o]),
         .credit_avail (credit_avail[o]),
         .error        (op_error[o])
      );
   end

   // sticky until the next reset
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         error_q <= 1'b0;
      else if (|{ip_error, op_error})
         error_q <= 1'b1;
   end

   assign error = error_q;

endmodule

//--- rtr_top_chk.sv
// concurrent checks on grants, sticky error, output valids and credit return, bound into the router
module rtr_top_chk
(
   input logic                                                clk,
   input logic                                                arst_n,
   input rtr_cfg_pkg::port_vec_t [rtr_cfg_pkg::num_ports-1:0] op_grant,
   input rtr_flit_pkg::flit_arr_t                             channel_in,
   input rtr_flit_pkg::flit_arr_t                             channel_out,
   input rtr_cfg_pkg::port_vec_t                              flit_sent,
   input rtr_cfg_pkg::port_vec_t                              flow_ctrl_out,
   input logic                                                error
);
   import rtr_cfg_pkg::*;
   import rtr_flit_pkg::*;

   // failed assertions, read back by the testbench
   int fail_cnt = 0;

   a_error_sticky : assert property (@(posedge clk) disable iff (!arst_n) !$fell(error))
      else
      begin
         $error("error output fell without reset");
         fail_cnt++;
      end

   for (genvar p = 0; p < num_ports; p++)
   begin : g_port
      // flits held in this input buffer, seen from the link side
      logic [2:0] occ_q;
      // outputs granting this input, the pop strobe is their or
      port_vec_t  ip_grant;

      always_ff @(posedge clk or negedge arst_n)
      begin
         if (!arst_n)
            occ_q <= '0;
         else if (channel_in[p].valid && occ_q != 3'd4 && !(flit_sent[p] && occ_q != 3'd0))
            occ_q <= occ_q + 3'd1;
         else if (flit_sent[p] && occ_q != 3'd0 && !(channel_in[p].valid && occ_q != 3'd4))
            occ_q <= occ_q - 3'd1;
      end

      always_comb
      begin
         for (int o = 0; o < num_ports; o++)
            ip_grant[o] = op_grant[o][p];
      end

      a_grant_onehot : assert property (@(posedge clk) disable iff (!arst_n)
         $onehot0(ip_grant))
         else
         begin
            $error("input granted by more than one output");
            fail_cnt++;
         end

      a_valid_known : assert property (@(posedge clk) disable iff (!arst_n)
         !$isunknown(channel_out[p].valid))
         else
         begin
            $error("output valid is unknown");
            fail_cnt++;
         end

      // back to back returns need a second flit behind the first pop
      a_credit_pair : assert property (@(posedge clk) disable iff (!arst_n)
         flow_ctrl_out[p] && $past(flow_ctrl_out[p]) |->
            $past(occ_q >= 3'd2 || channel_in[p].valid, 2))
         else
         begin
            $error("two credit returns from a single buffered flit");
            fail_cnt++;
         end
   end

endmodule

bind rtr_top rtr_top_chk chk
(
   .clk           (clk),
   .arst_n        (arst_n),
   .op_grant      (op_grant),
   .channel_in    (channel_in),
   .channel_out   (channel_out),
   .flit_sent     (flit_sent),
   .flow_ctrl_out (flow_ctrl_out),
   .error         (error)
);

//--- tb_rtr_top.sv
// self-checking testbench for the mesh router, runs the packet table against credit and scoreboard models
module tb_rtr_top;
   import rtr_cfg_pkg::*;
   import rtr_flit_pkg::*;

   // one row per packet, test groups the packets sent together
   typedef struct packed
   {
      logic [2:0]   test;
      port_idx_t    src;
      router_addr_t dst;
      logic [1:0]   len;
      logic [7:0]   base;
   } pkt_row_t;

   // stall holds back credit returns on one output, ovf pushes one flit past the upstream credit
   typedef struct packed
   {
      port_idx_t  stall_port;
      logic [7:0] stall_cycles;
      logic       ovf;
   } test_row_t;

   localparam int           num_tests = 5;
   localparam int           num_pkts  = 14;
   // x=1 y=2
   localparam router_addr_t my_addr   = 4'h9;

   pkt_row_t pkt_tab [num_pkts] = '{
      // test, src, dst, len, base
      '{3'd0, 3'd4, 4'h8, 2'd1, 8'h10},
      '{3'd0, 3'd0, 4'hb, 2'd1, 8'h11},
      '{3'd0, 3'd1, 4'h1, 2'd1, 8'h12},
      '{3'd0, 3'd2, 4'hd, 2'd1, 8'h13},
      '{3'd0, 3'd3, 4'h9, 2'd1, 8'h14},
      // x decides before y
      '{3'd0, 3'd4, 4'hc, 2'd1, 8'h15},
      '{3'd1, 3'd0, 4'h9, 2'd3, 8'h20},
      '{3'd2, 3'd0, 4'h9, 2'd3, 8'h30},
      '{3'd2, 3'd2, 4'h9, 2'd3, 8'h31},
      '{3'd3, 3'd4, 4'hb, 2'd3, 8'h40},
      '{3'd3, 3'd4, 4'hf, 2'd3, 8'h41},
      '{3'd4, 3'd0, 4'h9, 2'd3, 8'h50},
      '{3'd4, 3'd0, 4'h9, 2'd3, 8'h51},
      '{3'd4, 3'd0, 4'h9, 2'd3, 8'h52}
   };

   test_row_t test_tab [num_tests] = '{
      '{port_node, 8'd0, 1'b0},
      '{port_node, 8'd0, 1'b0},
      '{port_node, 8'd0, 1'b0},
      '{port_x_plus, 8'd40, 1'b0},
      '{port_node, 8'd40, 1'b1}
   };

   string test_name [num_tests] = '{"routing", "wormhole", "contention", "back-pressure",
                                    "overflow error"};

   logic         clk;
   logic         arst_n;
   router_addr_t router_address;
   flit_arr_t    channel_in;
   flit_arr_t    channel_out;
   port_vec_t    flow_ctrl_in;
   port_vec_t    flow_ctrl_out;
   logic         error;

   // upstream senders, scoreboard and downstream credit state per port
   flit_t  send_q [num_ports][$];
   int     send_port [num_ports][$];
   flit_t  sb [num_ports][$];
   int     up_credit [num_ports];
   int     written [num_ports];
   int     pulses [num_ports];
   int     owed [num_ports];
   int     stall_left [num_ports];
   int     stall_rx [num_ports];
   logic   in_pkt [num_ports];
   logic   ovf_mode;
   int     errors = 0;
   int     test_errors = 0;
   int     tests_failed = 0;
   int     cycles = 0;
   int     cycle_limit;
   integer seed = 15545;

   rtr_top rtr_top_inst
   (
      .clk            (clk),
      .arst_n         (arst_n),
      .router_address (router_address),
      .channel_in     (channel_in),
      .flow_ctrl_out  (flow_ctrl_out),
      .channel_out    (channel_out),
      .flow_ctrl_in   (flow_ctrl_in),
      .error          (error)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #50 clk = ~clk;
   end

   // ------------------------------
   // helpers
   // ------------------------------

   task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                          input string what);
      if (actual !== expected)
      begin
         $display("Error at %0t: %s, got %0h expected %0h", $time, what, actual, expected);
         errors++;
         test_errors++;
      end
   endtask

   task automatic note_failure(input string what);
      $display("%s", what);
      errors++;
      test_errors++;
   endtask

   // x first, then y, equal address stays on the node
   function automatic int route_of(input router_addr_t dst);
      int dx;
      int dy;
      dx = int'(dst) % 4;
      dy = int'(dst) / 4;
      if (dx > int'(my_addr) % 4)
         return 1;
      if (dx < int'(my_addr) % 4)
         return 0;
      if (dy > int'(my_addr) / 4)
         return 3;
      if (dy < int'(my_addr) / 4)
         return 2;
      return 4;
   endfunction

   task automatic load_packet(input pkt_row_t row);
      flit_t f;
      int    op;
      op = route_of(row.dst);
      for (int n = 0; n < int'(row.len); n++)
      begin
         f.valid = 1'b1;
         f.head  = (n == 0);
         f.tail  = (n == int'(row.len) - 1);
         if (n == 0)
            f.data = {row.base, 4'h0, row.dst};
         else
            f.data = 16'($random(seed));
         send_q[row.src].push_back(f);
         send_port[row.src].push_back(op);
         sb[op].push_back(f);
      end
   endtask

   // arbitration order between packets is open, so move the arriving one to the front
   task automatic bring_packet_front(input int p, input flit_t head);
      flit_t moved [$];
      flit_t f;
      int    j;
      logic  done;
      j = -1;
      for (int k = 0; k < sb[p].size(); k++)
      begin
         if (j < 0 && sb[p][k] == head)
            j = k;
      end
      if (j > 0)
      begin
         done = 1'b0;
         while (!done && j < sb[p].size())
         begin
            f = sb[p][j];
            moved.push_back(f);
            done = f.tail;
            sb[p].delete(j);
         end
         while (moved.size() > 0)
            sb[p].push_front(moved.pop_back());
      end
   endtask

   task automatic check_flit(input int p, input flit_t got);
      flit_t exp;
      if (got.head && in_pkt[p])
         note_failure($sformatf("head flit on output %0d arrived inside another packet", p));
      if (got.head)
         bring_packet_front(p, got);
      if (sb[p].size() == 0)
         note_failure($sformatf("unexpected flit on output %0d at %0t", p, $time));
      else
      begin
         exp = sb[p].pop_front();
         compare(got, exp, $sformatf("flit on output %0d", p));
      end
      in_pkt[p] = !got.tail;
   endtask

   // ------------------------------
   // link models
   // ------------------------------

   task automatic collect_outputs();
      flit_t got;
      for (int p = 0; p < num_ports; p++)
      begin
         if (flow_ctrl_out[p])
         begin
            pulses[p]++;
            up_credit[p]++;
         end
         got = channel_out[p];
         if (got.valid)
         begin
            owed[p]++;
            if (stall_left[p] > 0)
               stall_rx[p]++;
            check_flit(p, got);
         end
      end
   endtask

   task automatic drive_inputs();
      int op;
      for (int p = 0; p < num_ports; p++)
      begin
         channel_in[p] = '0;
         if (send_q[p].size() > 0 && up_credit[p] > 0)
         begin
            channel_in[p] = send_q[p].pop_front();
            void'(send_port[p].pop_front());
            up_credit[p]--;
            written[p]++;
         end
         else if (ovf_mode && send_q[p].size() == 1)
         begin
            // no credit left, this flit hits a full buffer and is lost
            channel_in[p] = send_q[p].pop_front();
            op = send_port[p].pop_front();
            void'(sb[op].pop_back());
         end
         // downstream returns one credit per flit unless stalled
         flow_ctrl_in[p] = 1'b0;
         if (stall_left[p] > 0)
            stall_left[p]--;
         else if (owed[p] > 0)
         begin
            flow_ctrl_in[p] = 1'b1;
            owed[p]--;
         end
      end
   endtask

   always @(posedge clk)
   begin
      #10;
      if (arst_n)
      begin
         collect_outputs();
         drive_inputs();
      end
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycles > cycle_limit)
      begin
         $display("timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   // ------------------------------
   // test sequence
   // ------------------------------

   function automatic logic drained();
      logic d;
      d = 1'b1;
      for (int p = 0; p < num_ports; p++)
      begin
         if (send_q[p].size() != 0 || sb[p].size() != 0 || owed[p] != 0 || stall_left[p] != 0)
            d = 1'b0;
      end
      return d;
   endfunction

   task automatic apply_reset();
      arst_n       = 1'b0;
      channel_in   = '0;
      flow_ctrl_in = '0;
      for (int p = 0; p < num_ports; p++)
      begin
         send_q[p].delete();
         send_port[p].delete();
         sb[p].delete();
         up_credit[p]  = buffer_depth;
         owed[p]       = 0;
         stall_left[p] = 0;
         in_pkt[p]     = 1'b0;
      end
      repeat (3) @(posedge clk);
      #20;
      arst_n = 1'b1;
   endtask

   task automatic run_test(input int t);
      test_row_t row;
      row = test_tab[t];
      @(negedge clk);
      test_errors = 0;
      ovf_mode    = row.ovf;
      for (int p = 0; p < num_ports; p++)
      begin
         written[p]  = 0;
         pulses[p]   = 0;
         stall_rx[p] = 0;
      end
      if (row.stall_cycles != 0)
         stall_left[row.stall_port] = int'(row.stall_cycles);
      for (int k = 0; k < num_pkts; k++)
      begin
         if (int'(pkt_tab[k].test) == t)
            load_packet(pkt_tab[k]);
      end
      do
         @(negedge clk);
      while (!drained());
      for (int p = 0; p < num_ports; p++)
         compare(pulses[p], written[p], $sformatf("credit returns on input %0d", p));
      if (row.stall_cycles != 0)
         compare(stall_rx[row.stall_port], buffer_depth, "flits sent while stalled");
      compare(error, row.ovf, "error output");
      ovf_mode = 1'b0;
      $display("test %0d %s: %s", t, test_name[t], (test_errors == 0) ? "ok" : "failed");
      if (test_errors != 0)
         tests_failed++;
   endtask

   initial
   begin
      arst_n         = 1'b0;
      router_address = my_addr;
      channel_in     = '0;
      flow_ctrl_in   = '0;
      ovf_mode       = 1'b0;
      cycle_limit    = 200;
      for (int k = 0; k < num_pkts; k++)
         cycle_limit += 20 * int'(pkt_tab[k].len);
      apply_reset();
      for (int t = 0; t < num_tests; t++)
         run_test(t);
      // the sticky error only clears on reset
      @(posedge clk);
      #20;
      apply_reset();
      @(negedge clk);
      test_errors = 0;
      compare(error, 1'b0, "error after reset");
      compare(flow_ctrl_out, '0, "credit returns after reset");
      compare(rtr_top_inst.chk.fail_cnt, 0, "assertion failures");
      $display("test %0d reset: %s", num_tests, (test_errors == 0) ? "ok" : "failed");
      if (test_errors != 0)
         tests_failed++;
      $display("tests run %0d, failed %0d, errors %0d", num_tests + 1, tests_failed, errors);
      if (errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

//--- build.f
rtr_cfg_pkg.sv
rtr_flit_pkg.sv
rtr_flit_fifo.sv
rtr_ip_ctrl.sv
rtr_sw_alloc.sv
rtr_op_ctrl.sv
rtr_top.sv
rtr_top_chk.sv
tb_rtr_top.sv

//--- Makefile
TOP = tb_rtr_top

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "RESULT: PASS" sim.log

obj_dir/V$(TOP): build.f $(wildcard *.sv)
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall --timing --assert -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
